/* design/fencei_pkg.sv */
`default_nettype none

package fencei_pkg;

  // pcs, addresses and data words share one width
  typedef logic [31:0] pc_t;

  // I-type layout, used to spot fence.i
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  // S-type layout, immediate split around rs2/rs1
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } instr_s_t;

  // one fetched word seen through either format
  typedef union packed {
    instr_i_t i;
    instr_s_t s;
  } instr_u;

  typedef enum logic [1:0] {
    CLASS_OTHER  = 2'd0,
    CLASS_STORE  = 2'd1,
    CLASS_FENCEI = 2'd2
  } instr_class_e;

  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [2:0] F3_FENCEI    = 3'b001;
  localparam logic [2:0] F3_SW        = 3'b010;

endpackage

`default_nettype wire

/* design/fencei_decode_stage.sv */
`default_nettype none

module fencei_decode_stage (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  input  wire                      instr_valid_i,
  input  fencei_pkg::pc_t          instr_pc_i,
  input  fencei_pkg::instr_u       instr_rdata_i,
  input  wire                      stall_i,
  output logic                     instr_ready_o,
  output logic                     dec_valid_o,
  output fencei_pkg::pc_t          dec_pc_o,
  output fencei_pkg::instr_class_e dec_class_o,
  output fencei_pkg::pc_t          dec_addr_o,
  output fencei_pkg::pc_t          dec_data_o
);

  logic                     accept;
  fencei_pkg::instr_class_e class_d;
  fencei_pkg::pc_t          addr_d;
  fencei_pkg::pc_t          data_d;

  // stays ready unless a held word sits in the register
  assign instr_ready_o = !dec_valid_o || !stall_i;
  assign accept        = instr_valid_i && instr_ready_o;

  // fence.i ignores imm, rs1 and rd
  always_comb begin
    if (instr_rdata_i.i.opcode == fencei_pkg::OPC_MISC_MEM &&
        instr_rdata_i.i.funct3 == fencei_pkg::F3_FENCEI) begin
      class_d = fencei_pkg::CLASS_FENCEI;
    end else if (instr_rdata_i.s.opcode == fencei_pkg::OPC_STORE &&
                 instr_rdata_i.s.funct3 == fencei_pkg::F3_SW) begin
      class_d = fencei_pkg::CLASS_STORE;
    end else begin
      class_d = fencei_pkg::CLASS_OTHER;
    end
  end

  // zero base register, so the address is just the immediate
  assign addr_d = {{20{instr_rdata_i.s.imm_hi[6]}}, instr_rdata_i.s.imm_hi,
                   instr_rdata_i.s.imm_lo};
  // rs2 index stands in for the register value
  assign data_d = {27'd0, instr_rdata_i.s.rs2};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_o <= 1'b0;
    end else if (accept) begin
      dec_valid_o <= 1'b1;
    end else if (!stall_i) begin
      dec_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_pc_o    <= instr_pc_i;
      dec_class_o <= class_d;
      dec_addr_o  <= addr_d;
      dec_data_o  <= data_d;
    end
  end

endmodule

`default_nettype wire

/* design/fencei_mem_stage.sv */
`default_nettype none

module fencei_mem_stage #(
  parameter int XLEN = 32
) (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  input  wire                      dec_valid_i,
  input  fencei_pkg::pc_t          dec_pc_i,
  input  fencei_pkg::instr_class_e dec_class_i,
  input  wire [XLEN-1:0]           dec_addr_i,
  input  wire [XLEN-1:0]           dec_data_i,
  input  wire                      stall_i,
  input  wire                      wb_ack_i,
  output logic                     stall_o,
  output logic                     mem_valid_o,
  output fencei_pkg::pc_t          mem_pc_o,
  output fencei_pkg::instr_class_e mem_class_o,
  output logic                     buf_empty_o,
  output logic                     wb_cyc_o,
  output logic                     wb_stb_o,
  output logic                     wb_we_o,
  output logic [XLEN-1:0]          wb_adr_o,
  output logic [XLEN-1:0]          wb_dat_o,
  output logic [XLEN/8-1:0]        wb_sel_o
);

  typedef enum logic {
    BUS_IDLE,
    BUS_ACTIVE
  } bus_state_e;

  bus_state_e      bus_state_q;
  logic            buf_valid_q;
  logic [XLEN-1:0] buf_adr_q;
  logic [XLEN-1:0] buf_dat_q;
  logic            is_store;
  logic            take;

  assign is_store = dec_class_i == fencei_pkg::CLASS_STORE;

  // hold upstream if retire is frozen or a second store finds the buffer full
  assign stall_o = dec_valid_i &&
                   ((mem_valid_o && stall_i) || (is_store && buf_valid_q));
  assign take    = dec_valid_i && !stall_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_valid_o <= 1'b0;
    end else if (take) begin
      mem_valid_o <= 1'b1;
    end else if (!stall_i) begin
      mem_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      mem_pc_o    <= dec_pc_i;
      mem_class_o <= dec_class_i;
    end
  end

  // store counts as done once it is in the buffer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_valid_q <= 1'b0;
    end else if (take && is_store) begin
      buf_valid_q <= 1'b1;
    end else if (bus_state_q == BUS_ACTIVE && wb_ack_i) begin
      buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take && is_store) begin
      buf_adr_q <= dec_addr_i;
      buf_dat_q <= dec_data_i;
    end
  end

  // a filled buffer opens the bus cycle one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_state_q <= BUS_IDLE;
    end else begin
      case (bus_state_q)
        BUS_IDLE: begin
          if (buf_valid_q) begin
            bus_state_q <= BUS_ACTIVE;
          end
        end
        default: begin
          if (wb_ack_i) begin
            bus_state_q <= BUS_IDLE;
          end
        end
      endcase
    end
  end

  assign wb_cyc_o = bus_state_q == BUS_ACTIVE;
  assign wb_stb_o = bus_state_q == BUS_ACTIVE;
  assign wb_we_o  = bus_state_q == BUS_ACTIVE;
  assign wb_adr_o = buf_adr_q;
  assign wb_dat_o = buf_dat_q;
  // word stores only
  assign wb_sel_o = '1;

  assign buf_empty_o = !buf_valid_q && (bus_state_q == BUS_IDLE);

endmodule

`default_nettype wire

/* design/fencei_retire_stage.sv */
`default_nettype none

module fencei_retire_stage (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  input  wire                      mem_valid_i,
  input  fencei_pkg::pc_t          mem_pc_i,
  input  fencei_pkg::instr_class_e mem_class_i,
  input  wire                      buf_empty_i,
  input  wire                      fencei_flush_ack_i,
  output logic                     stall_o,
  output logic                     fencei_flush_req_o,
  output logic                     retire_valid_o,
  output fencei_pkg::pc_t          retire_pc_o,
  output logic                     retire_fencei_o,
  output logic                     redirect_valid_o,
  output fencei_pkg::pc_t          redirect_pc_o
);

  typedef enum logic [1:0] {
    RET_IDLE,
    RET_WAIT_DRAIN,
    RET_FLUSH
  } ret_state_e;

  ret_state_e      state_q;
  logic            is_fencei;
  logic            flush_done;
  logic            ord_valid_q;
  fencei_pkg::pc_t ord_pc_q;

  assign is_fencei  = mem_valid_i && (mem_class_i == fencei_pkg::CLASS_FENCEI);
  assign flush_done = fencei_flush_req_o && fencei_flush_ack_i;

  // fence.i stays in the memory stage register until the agent acks
  assign stall_o = is_fencei && !flush_done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RET_IDLE;
    end else begin
      case (state_q)
        RET_IDLE: begin
          if (is_fencei) begin
            state_q <= buf_empty_i ? RET_FLUSH : RET_WAIT_DRAIN;
          end
        end
        RET_WAIT_DRAIN: begin
          if (buf_empty_i) begin
            state_q <= RET_FLUSH;
          end
        end
        default: begin
          if (fencei_flush_ack_i) begin
            state_q <= RET_IDLE;
          end
        end
      endcase
    end
  end

  assign fencei_flush_req_o = state_q == RET_FLUSH;

  // ordinary instructions retire one cycle after arrival
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ord_valid_q <= 1'b0;
    end else begin
      ord_valid_q <= mem_valid_i && !is_fencei;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_valid_i && !is_fencei) begin
      ord_pc_q <= mem_pc_i;
    end
  end

  assign retire_valid_o   = ord_valid_q || flush_done;
  assign retire_fencei_o  = flush_done;
  assign retire_pc_o      = flush_done ? mem_pc_i : ord_pc_q;

  // resume at the word after the fence.i
  assign redirect_valid_o = flush_done;
  assign redirect_pc_o    = {mem_pc_i[31:2], 2'b00} + 32'd4;

endmodule

`default_nettype wire

/* design/fencei_flush_monitor.sv */
`default_nettype none

module fencei_flush_monitor (
  input  wire  clk_i,
  input  wire  rst_ni,
  input  wire  fencei_flush_req_i,
  input  wire  fencei_flush_ack_i,
  input  wire  wb_cyc_i,
  input  wire  wb_stb_i,
  input  wire  wb_ack_i,
  output logic protocol_err_o
);

  logic [1:0] open_cnt_q;
  logic       strobe_q;
  logic       wb_ack_q;
  logic       req_q;
  logic       ack_q;
  logic       strobe;
  logic       bus_start;
  logic       bus_done;
  logic       err;

  assign strobe    = wb_cyc_i && wb_stb_i;
  // new cycle when strobe rises or follows an ack back to back
  assign bus_start = strobe && (!strobe_q || wb_ack_q);
  assign bus_done  = strobe && wb_ack_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      open_cnt_q <= 2'd0;
      strobe_q   <= 1'b0;
      wb_ack_q   <= 1'b0;
      req_q      <= 1'b0;
      ack_q      <= 1'b0;
    end else begin
      open_cnt_q <= open_cnt_q + {1'b0, bus_start} - {1'b0, bus_done};
      strobe_q   <= strobe;
      wb_ack_q   <= bus_done;
      req_q      <= fencei_flush_req_i;
      ack_q      <= fencei_flush_req_i && fencei_flush_ack_i;
    end
  end

  always_comb begin
    err = 1'b0;
    // req dropped before any ack
    if (req_q && !fencei_flush_req_i && !ack_q) begin
      err = 1'b1;
    end
    // req still high the cycle after ack
    if (ack_q && fencei_flush_req_i) begin
      err = 1'b1;
    end
    if (fencei_flush_req_i && wb_cyc_i) begin
      err = 1'b1;
    end
    if (fencei_flush_req_i && !req_q && open_cnt_q != 2'd0) begin
      err = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      protocol_err_o <= 1'b0;
    end else if (err) begin
      protocol_err_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/fencei_top.sv */
`default_nettype none

module fencei_top #(
  parameter int XLEN = 32
) (
  input  wire                clk_i,
  input  wire                rst_ni,
  input  wire                instr_valid_i,
  input  fencei_pkg::pc_t    instr_pc_i,
  input  fencei_pkg::instr_u instr_rdata_i,
  output logic               instr_ready_o,
  output logic               wb_cyc_o,
  output logic               wb_stb_o,
  output logic               wb_we_o,
  output logic [XLEN-1:0]    wb_adr_o,
  output logic [XLEN-1:0]    wb_dat_o,
  output logic [XLEN/8-1:0]  wb_sel_o,
  input  wire                wb_ack_i,
  output logic               fencei_flush_req_o,
  input  wire                fencei_flush_ack_i,
  output logic               retire_valid_o,
  output fencei_pkg::pc_t    retire_pc_o,
  output logic               retire_fencei_o,
  output logic               redirect_valid_o,
  output fencei_pkg::pc_t    redirect_pc_o,
  output logic               protocol_err_o
);

  logic                     dec_valid;
  fencei_pkg::pc_t          dec_pc;
  fencei_pkg::instr_class_e dec_class;
  fencei_pkg::pc_t          dec_addr;
  fencei_pkg::pc_t          dec_data;
  logic                     mem_stall;
  logic                     mem_valid;
  fencei_pkg::pc_t          mem_pc;
  fencei_pkg::instr_class_e mem_class;
  logic                     buf_empty;
  logic                     ret_stall;

  fencei_decode_stage decode_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_pc_i    (instr_pc_i),
    .instr_rdata_i (instr_rdata_i),
    .stall_i       (mem_stall),
    .instr_ready_o (instr_ready_o),
    .dec_valid_o   (dec_valid),
    .dec_pc_o      (dec_pc),
    .dec_class_o   (dec_class),
    .dec_addr_o    (dec_addr),
    .dec_data_o    (dec_data)
  );

  fencei_mem_stage #(
    .XLEN (XLEN)
  ) mem_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .dec_valid_i (dec_valid),
    .dec_pc_i    (dec_pc),
    .dec_class_i (dec_class),
    .dec_addr_i  (dec_addr),
    .dec_data_i  (dec_data),
    .stall_i     (ret_stall),
    .wb_ack_i    (wb_ack_i),
    .stall_o     (mem_stall),
    .mem_valid_o (mem_valid),
    .mem_pc_o    (mem_pc),
    .mem_class_o (mem_class),
    .buf_empty_o (buf_empty),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_we_o     (wb_we_o),
    .wb_adr_o    (wb_adr_o),
    .wb_dat_o    (wb_dat_o),
    .wb_sel_o    (wb_sel_o)
  );

  fencei_retire_stage retire_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .mem_valid_i        (mem_valid),
    .mem_pc_i           (mem_pc),
    .mem_class_i        (mem_class),
    .buf_empty_i        (buf_empty),
    .fencei_flush_ack_i (fencei_flush_ack_i),
    .stall_o            (ret_stall),
    .fencei_flush_req_o (fencei_flush_req_o),
    .retire_valid_o     (retire_valid_o),
    .retire_pc_o        (retire_pc_o),
    .retire_fencei_o    (retire_fencei_o),
    .redirect_valid_o   (redirect_valid_o),
    .redirect_pc_o      (redirect_pc_o)
  );

  // checks the handshake and the data bus as seen at the ports
  fencei_flush_monitor monitor_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .fencei_flush_req_i (fencei_flush_req_o),
    .fencei_flush_ack_i (fencei_flush_ack_i),
    .wb_cyc_i           (wb_cyc_o),
    .wb_stb_i           (wb_stb_o),
    .wb_ack_i           (wb_ack_i),
    .protocol_err_o     (protocol_err_o)
  );

endmodule

`default_nettype wire

/* sim/fencei_tb.sv */
`default_nettype none

module fencei_tb;

  localparam int N_ROWS = 14;
  // delay column value that is replaced by a random draw
  localparam int RND    = 99;

  logic               clk_i = 1'b0;
  logic               rst_ni;
  logic               instr_valid_i;
  fencei_pkg::pc_t    instr_pc_i;
  fencei_pkg::instr_u instr_rdata_i;
  logic               instr_ready_o;
  logic               wb_cyc_o;
  logic               wb_stb_o;
  logic               wb_we_o;
  fencei_pkg::pc_t    wb_adr_o;
  fencei_pkg::pc_t    wb_dat_o;
  logic [3:0]         wb_sel_o;
  logic               wb_ack_i = 1'b0;
  logic               fencei_flush_req_o;
  logic               fencei_flush_ack_i = 1'b0;
  logic               retire_valid_o;
  fencei_pkg::pc_t    retire_pc_o;
  logic               retire_fencei_o;
  logic               redirect_valid_o;
  fencei_pkg::pc_t    redirect_pc_o;
  logic               protocol_err_o;

  // stimulus table
  fencei_pkg::pc_t          row_pc   [N_ROWS];
  logic [31:0]              row_word [N_ROWS];
  fencei_pkg::instr_class_e row_cls  [N_ROWS];
  int                       row_wb   [N_ROWS];
  int                       row_fl   [N_ROWS];
  int                       n_rows = 0;

  int store_row     [N_ROWS];
  int fence_row     [N_ROWS];
  int stores_before [N_ROWS];
  int n_stores = 0;
  int n_fences = 0;

  // checker state
  int   row_errs [N_ROWS];
  logic retired  [N_ROWS];
  logic written  [N_ROWS];
  int   ret_seen  = 0;
  int   wr_seen   = 0;
  int   req_seen  = 0;
  int   rows_done = 0;
  int   pass_cnt  = 0;
  int   fail_cnt  = 0;
  int   misc_errs = 0;
  logic prev_req  = 1'b0;
  logic prev_ack  = 1'b0;

  // responder state
  int wb_wait  = 0;
  int wb_done  = 0;
  int fl_wait  = 0;
  int fl_done  = 0;

  fencei_top #(
    .XLEN (32)
  ) fencei_top_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .instr_valid_i      (instr_valid_i),
    .instr_pc_i         (instr_pc_i),
    .instr_rdata_i      (instr_rdata_i),
    .instr_ready_o      (instr_ready_o),
    .wb_cyc_o           (wb_cyc_o),
    .wb_stb_o           (wb_stb_o),
    .wb_we_o            (wb_we_o),
    .wb_adr_o           (wb_adr_o),
    .wb_dat_o           (wb_dat_o),
    .wb_sel_o           (wb_sel_o),
    .wb_ack_i           (wb_ack_i),
    .fencei_flush_req_o (fencei_flush_req_o),
    .fencei_flush_ack_i (fencei_flush_ack_i),
    .retire_valid_o     (retire_valid_o),
    .retire_pc_o        (retire_pc_o),
    .retire_fencei_o    (retire_fencei_o),
    .redirect_valid_o   (redirect_valid_o),
    .redirect_pc_o      (redirect_pc_o),
    .protocol_err_o     (protocol_err_o)
  );

  always #2 clk_i = ~clk_i;

  // instruction encoders
  function automatic logic [31:0] enc_addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_sw(logic [11:0] imm, logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_fencei(logic [11:0] imm, logic [4:0] rs1, logic [4:0] rd);
    return {imm, rs1, 3'b001, rd, 7'b0001111};
  endfunction

  task automatic add_row(fencei_pkg::pc_t pc, logic [31:0] word,
                         fencei_pkg::instr_class_e cls, int wb_dly, int fl_dly);
    row_pc[n_rows]   = pc;
    row_word[n_rows] = word;
    row_cls[n_rows]  = cls;
    row_wb[n_rows]   = wb_dly;
    row_fl[n_rows]   = fl_dly;
    n_rows++;
  endtask

  task automatic load_table();
    add_row(32'h100, enc_addi(5'd1, 5'd0, 12'h001), fencei_pkg::CLASS_OTHER, 0, 0);
    add_row(32'h104, enc_sw(12'h010, 5'd5), fencei_pkg::CLASS_STORE, 2, 0);
    add_row(32'h108, enc_fencei(12'h000, 5'd0, 5'd0), fencei_pkg::CLASS_FENCEI, 0, 1);
    add_row(32'h10c, enc_addi(5'd2, 5'd1, 12'h7ff), fencei_pkg::CLASS_OTHER, 0, 0);
    add_row(32'h110, enc_sw(12'h800, 5'd31), fencei_pkg::CLASS_STORE, RND, 0);
    add_row(32'h114, enc_sw(12'h7fc, 5'd1), fencei_pkg::CLASS_STORE, RND, 0);
    // unaligned pc, reserved fields set
    add_row(32'h11a, enc_fencei(12'habc, 5'd5, 5'd3), fencei_pkg::CLASS_FENCEI, 0, RND);
    add_row(32'h120, enc_fencei(12'h000, 5'd0, 5'd0), fencei_pkg::CLASS_FENCEI, 0, 0);
    // plain fence shares the opcode
    add_row(32'h124, 32'h0ff0000f, fencei_pkg::CLASS_OTHER, 0, 0);
    add_row(32'h128, enc_sw(12'hfff, 5'd7), fencei_pkg::CLASS_STORE, 4, 0);
    add_row(32'h12c, enc_fencei(12'hfff, 5'd31, 5'd31), fencei_pkg::CLASS_FENCEI, 0, 4);
    add_row(32'h130, enc_sw(12'h020, 5'd0), fencei_pkg::CLASS_STORE, 0, 0);
    add_row(32'h134, enc_sw(12'h024, 5'd9), fencei_pkg::CLASS_STORE, RND, 0);
    add_row(32'h138, enc_fencei(12'h123, 5'd0, 5'd7), fencei_pkg::CLASS_FENCEI, 0, RND);
  endtask

  function automatic int wb_delay(int k);
    if (k < n_stores) begin
      return row_wb[store_row[k]];
    end
    return 0;
  endfunction

  function automatic int fl_delay(int k);
    if (k < n_fences) begin
      return row_fl[fence_row[k]];
    end
    return 0;
  endfunction

  task automatic report_error(int r, string msg);
    $display("Error at %0t: %s", $time, msg);
    if (r >= 0) begin
      row_errs[r]++;
    end else begin
      misc_errs++;
    end
  endtask

  task automatic check_pc(fencei_pkg::pc_t got, fencei_pkg::pc_t exp, string what, int r);
    if (got !== exp) begin
      $display("Mismatch at %0t: test %0d %s got %08h expected %08h", $time, r, what, got, exp);
      row_errs[r]++;
    end
  endtask

  task automatic check_class(logic fencei_flag, fencei_pkg::instr_class_e exp, int r);
    if (fencei_flag !== (exp == fencei_pkg::CLASS_FENCEI)) begin
      $display("Mismatch at %0t: test %0d fence.i flag %0b for class %s",
               $time, r, fencei_flag, exp.name());
      row_errs[r]++;
    end
  endtask

  task automatic check_bus(fencei_pkg::pc_t adr, fencei_pkg::pc_t dat, logic [3:0] sel, int r);
    fencei_pkg::pc_t exp_adr;
    fencei_pkg::pc_t exp_dat;
    // sign-extended S immediate, data is the rs2 index
    exp_adr = {{20{row_word[r][31]}}, row_word[r][31:25], row_word[r][11:7]};
    exp_dat = {27'd0, row_word[r][24:20]};
    if (adr !== exp_adr || dat !== exp_dat || sel !== 4'hf) begin
      $display("Mismatch at %0t: test %0d write %08h/%08h sel %h expected %08h/%08h sel f",
               $time, r, adr, dat, sel, exp_adr, exp_dat);
      row_errs[r]++;
    end
  endtask

  task automatic finish_row(int r);
    if (row_errs[r] == 0) begin
      pass_cnt++;
      $display("test %0d %s at pc %08h passed", r, row_cls[r].name(), row_pc[r]);
    end else begin
      fail_cnt++;
      $display("test %0d %s at pc %08h failed with %0d errors",
               r, row_cls[r].name(), row_pc[r], row_errs[r]);
    end
    rows_done++;
  endtask

  task automatic record_retire();
    int r;
    r = ret_seen;
    ret_seen++;
    if (r >= N_ROWS) begin
      report_error(-1, "retire beyond the end of the table");
      return;
    end
    check_pc(retire_pc_o, row_pc[r], "retire pc", r);
    check_class(retire_fencei_o, row_cls[r], r);
    if (row_cls[r] == fencei_pkg::CLASS_FENCEI) begin
      if (!redirect_valid_o) begin
        report_error(r, "no redirect together with the fence.i retire");
      end else begin
        check_pc(redirect_pc_o, {row_pc[r][31:2], 2'b00} + 32'd4, "redirect pc", r);
      end
    end else if (redirect_valid_o) begin
      report_error(r, "redirect on a retire that is not fence.i");
    end
    retired[r] = 1'b1;
    if (row_cls[r] != fencei_pkg::CLASS_STORE || written[r]) begin
      finish_row(r);
    end
  endtask

  task automatic record_write();
    int k;
    int r;
    k = wr_seen;
    wr_seen++;
    if (k >= n_stores) begin
      report_error(-1, "bus write with no store left in the table");
      return;
    end
    r = store_row[k];
    check_bus(wb_adr_o, wb_dat_o, wb_sel_o, r);
    if (!wb_we_o) begin
      report_error(r, "bus cycle completed with we low");
    end
    written[r] = 1'b1;
    if (retired[r]) begin
      finish_row(r);
    end
  endtask

  task automatic check_handshake();
    int r;
    if (prev_req && prev_ack && fencei_flush_req_o) begin
      report_error(-1, "flush req still high the cycle after ack");
    end
    if (prev_req && !prev_ack && !fencei_flush_req_o) begin
      report_error(-1, "flush req dropped before ack");
    end
    if (fencei_flush_req_o && wb_cyc_o) begin
      report_error(-1, "flush req high while a bus cycle is open");
    end
    if (fencei_flush_req_o && !prev_req) begin
      if (req_seen >= n_fences) begin
        report_error(-1, "flush req with no fence.i left in the table");
      end else begin
        r = fence_row[req_seen];
        if (wr_seen < stores_before[r]) begin
          report_error(r, "flush req before every earlier store was acked");
        end
      end
      req_seen++;
    end
  endtask

  // all output checks at the falling edge, where outputs are settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (retire_valid_o) begin
        record_retire();
      end else if (redirect_valid_o) begin
        report_error(-1, "redirect pulse without a retire");
      end
      if (wb_cyc_o && wb_stb_o && wb_ack_i) begin
        record_write();
      end
      check_handshake();
      prev_req = fencei_flush_req_o;
      prev_ack = fencei_flush_ack_i;
    end
  end

  // wishbone slave, ack is registered and held one cycle
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      wb_ack_i <= 1'b0;
      wb_wait = 0;
    end else if (wb_ack_i) begin
      wb_ack_i <= 1'b0;
      wb_wait = 0;
      wb_done++;
    end else if (wb_cyc_o && wb_stb_o) begin
      if (wb_wait >= wb_delay(wb_done)) begin
        wb_ack_i <= 1'b1;
      end else begin
        wb_wait++;
      end
    end
  end

  // icache flush agent
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      fencei_flush_ack_i <= 1'b0;
      fl_wait = 0;
    end else if (fencei_flush_ack_i) begin
      fencei_flush_ack_i <= 1'b0;
      fl_wait = 0;
      fl_done++;
    end else if (fencei_flush_req_o) begin
      if (fl_wait >= fl_delay(fl_done)) begin
        fencei_flush_ack_i <= 1'b1;
      end else begin
        fl_wait++;
      end
    end
  end

  initial begin : watchdog
    repeat (N_ROWS * 40 + 200) @(posedge clk_i);
    $display("timed out waiting for all instructions to retire");
    $display("TEST FAIL");
    $finish;
  end

  initial begin : main
    int end_errs;
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_pc_i    = '0;
    instr_rdata_i = '0;
    end_errs      = 0;
    void'($urandom(55));
    load_table();
    for (int r = 0; r < N_ROWS; r++) begin
      row_errs[r] = 0;
      retired[r]  = 1'b0;
      written[r]  = 1'b0;
      if (row_wb[r] == RND) begin
        row_wb[r] = $urandom_range(4, 0);
      end
      if (row_fl[r] == RND) begin
        row_fl[r] = $urandom_range(4, 0);
      end
      stores_before[r] = n_stores;
      if (row_cls[r] == fencei_pkg::CLASS_STORE) begin
        store_row[n_stores] = r;
        n_stores++;
      end
      if (row_cls[r] == fencei_pkg::CLASS_FENCEI) begin
        fence_row[n_fences] = r;
        n_fences++;
      end
    end

    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (fencei_flush_req_o || wb_cyc_o || wb_stb_o || retire_valid_o ||
        redirect_valid_o || protocol_err_o || !instr_ready_o) begin
      $display("Error at %0t: outputs not at their reset values", $time);
      end_errs++;
    end

    @(posedge clk_i);
    for (int r = 0; r < N_ROWS; r++) begin
      instr_valid_i <= 1'b1;
      instr_pc_i    <= row_pc[r];
      instr_rdata_i <= row_word[r];
      @(posedge clk_i);
      // held until the DUT takes it
      while (!instr_ready_o) @(posedge clk_i);
    end
    instr_valid_i <= 1'b0;

    while (rows_done < N_ROWS) @(posedge clk_i);
    // room for a late duplicate retire or write
    repeat (20) @(posedge clk_i);

    if (wr_seen != n_stores) begin
      $display("Error at %0t: %0d bus writes for %0d stores", $time, wr_seen, n_stores);
      end_errs++;
    end
    if (protocol_err_o) begin
      $display("Error at %0t: flush monitor raised its error flag", $time);
      end_errs++;
    end
    $display("tests passed %0d, failed %0d, other errors %0d",
             pass_cnt, fail_cnt, misc_errs + end_errs);
    if (fail_cnt == 0 && misc_errs == 0 && end_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* fencei_top.f */
design/fencei_pkg.sv
design/fencei_decode_stage.sv
design/fencei_mem_stage.sv
design/fencei_retire_stage.sv
design/fencei_flush_monitor.sv
design/fencei_top.sv
sim/fencei_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f fencei_top.f \
  --top-module fencei_tb \
  -o fencei_sim

./obj_dir/fencei_sim | tee sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
